//--- vlog.f
+incdir+src
src/snap_regs_pkg.sv
src/axil_ctrl.sv
src/reg_bank.sv
src/action_ctrl.sv
src/read_mux.sv
src/snap_regs_top.sv
verif/tb_snap_regs.sv

//--- Makefile
# Verilator build and run for the SNAP register slave

VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only -Wall --timing
TOP        ?= tb_snap_regs
FILELIST   ?= vlog.f
OBJ_DIR    ?= obj_dir
PASS_MSG   := TESTBENCH PASSED

.PHONY: all run lint clean

all: run

run:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- verif/tb_snap_regs.sv
//----------------------------------------------------------------------
// Testbench for the AXI-Lite SNAP register slave
// Random bus traffic checked against a register model
//----------------------------------------------------------------------
`timescale 1ns/1ps
`include "snap_regs_defs.svh"

module tb_snap_regs;

   // Test lengths and the cycle budget derived from them
   localparam int N_RAND     = 24;
   localparam int N_BP       = 8;
   localparam int N_OPS      = 2*N_RAND + 7 + 3 + 5 + 6 + 12 + 2*N_BP;
   localparam int MAX_CYCLES = 40*N_OPS + 20;

   logic                    clk;
   logic                    rst_n;
   logic                    awvalid;
   logic [`SNAP_ADDR_W-1:0] awaddr;
   logic                    awready;
   logic                    wvalid;
   logic [`SNAP_DATA_W-1:0] wdata;
   logic [`SNAP_STRB_W-1:0] wstrb;
   logic                    wready;
   logic [1:0]              bresp;
   logic                    bvalid;
   logic                    bready;
   logic                    arvalid;
   logic [`SNAP_ADDR_W-1:0] araddr;
   logic                    arready;
   logic [`SNAP_DATA_W-1:0] rdata;
   logic [1:0]              rresp;
   logic                    rvalid;
   logic                    rready;
   logic                    done_pulse;
   logic                    rd_error;
   logic                    wr_error;
   logic [`SNAP_DATA_W-1:0] action_type;
   logic [`SNAP_DATA_W-1:0] action_version;
   logic                    start_pulse;
   logic [`SNAP_LONG_W-1:0] source_address;
   logic [`SNAP_LONG_W-1:0] target_address;
   logic [`SNAP_DATA_W-1:0] mb_w;
   logic [`SNAP_DATA_W-1:0] mb_h;
   logic [`SNAP_DATA_W-1:0] snap_context;

   int          errors = 0;
   int          checks = 0;
   int          cycles = 0;
   int          start_count = 0;
   logic [31:0] seed = 32'hbaca;

   // Register model
   logic [31:0] m_snap_control;
   logic [31:0] m_context;
   logic [31:0] m_user_control;
   logic [31:0] m_mb_w;
   logic [31:0] m_mb_h;
   logic [31:0] m_soft;
   logic [63:0] m_src;
   logic [63:0] m_tgt;
   logic        m_idle;
   logic        m_done;
   logic        m_rd_err;
   logic        m_wr_err;

   // Writable offsets without soft reset
   logic [31:0] rw_ofs [9] = '{`SNAP_OFS_SNAP_CONTROL, `SNAP_OFS_CONTEXT,
      `SNAP_OFS_USER_CONTROL, `SNAP_OFS_SOURCE_L, `SNAP_OFS_SOURCE_H, `SNAP_OFS_TARGET_L,
      `SNAP_OFS_TARGET_H, `SNAP_OFS_MB_W, `SNAP_OFS_MB_H};
   // Offsets that feed the configuration outputs
   logic [31:0] cfg_ofs [7] = '{`SNAP_OFS_SOURCE_L, `SNAP_OFS_SOURCE_H,
      `SNAP_OFS_TARGET_L, `SNAP_OFS_TARGET_H, `SNAP_OFS_MB_W, `SNAP_OFS_MB_H,
      `SNAP_OFS_CONTEXT};

   snap_regs_top i_dut (
      .clk            (clk),
      .rst_n          (rst_n),
      .awvalid        (awvalid),
      .awaddr         (awaddr),
      .awready        (awready),
      .wvalid         (wvalid),
      .wdata          (wdata),
      .wstrb          (wstrb),
      .wready         (wready),
      .bresp          (bresp),
      .bvalid         (bvalid),
      .bready         (bready),
      .arvalid        (arvalid),
      .araddr         (araddr),
      .arready        (arready),
      .rdata          (rdata),
      .rresp          (rresp),
      .rvalid         (rvalid),
      .rready         (rready),
      .done_pulse     (done_pulse),
      .rd_error       (rd_error),
      .wr_error       (wr_error),
      .action_type    (action_type),
      .action_version (action_version),
      .start_pulse    (start_pulse),
      .source_address (source_address),
      .target_address (target_address),
      .mb_w           (mb_w),
      .mb_h           (mb_h),
      .snap_context   (snap_context)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // Watchdog
   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= MAX_CYCLES) begin
         $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
         $display("Checks: %0d, errors: %0d", checks, errors);
         $display("TESTBENCH FAILED");
         $finish;
      end
   end

   // Start pulse cycles counted on the falling edge
   always @(negedge clk) begin
      if (start_pulse === 1'b1)
         start_count <= start_count + 1;
   end

   //-------------------------------------------------------------------
   // Helpers
   //-------------------------------------------------------------------
   function logic [31:0] next_rand();
      seed = seed * 32'd1664525 + 32'd1013904223;
      return seed;
   endfunction

   // Step to 1 ns past the next rising edge
   task automatic tick();
      @(posedge clk);
      #1;
   endtask

   task automatic compare(input string name, input logic [63:0] exp, input logic [63:0] got);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Error: %s expected %h actual %h", name, exp, got);
      end
   endtask

   function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                               input logic [31:0] new_word,
                                               input logic [3:0]  strb);
      logic [31:0] res;
      res = old_word;
      for (int i = 0; i < 4; i++) begin
         if (strb[i])
            res[8*i +: 8] = new_word[8*i +: 8];
      end
      return res;
   endfunction

   task automatic model_clear();
      m_snap_control = '0;
      m_context      = '0;
      m_user_control = '0;
      m_mb_w         = '0;
      m_mb_h         = '0;
      m_soft         = '0;
      m_src          = '0;
      m_tgt          = '0;
      m_idle         = 1'b0;
      m_done         = 1'b0;
      m_rd_err       = 1'b0;
      m_wr_err       = 1'b0;
   endtask

   task automatic model_write(input logic [31:0] addr, input logic [31:0] data,
                              input logic [3:0] strb);
      case (addr)
         `SNAP_OFS_SNAP_CONTROL: m_snap_control = merge_bytes(m_snap_control, data, strb);
         `SNAP_OFS_CONTEXT:      m_context      = merge_bytes(m_context, data, strb);
         `SNAP_OFS_USER_CONTROL: m_user_control = merge_bytes(m_user_control, data, strb);
         `SNAP_OFS_SOURCE_L:     m_src[31:0]    = merge_bytes(m_src[31:0], data, strb);
         `SNAP_OFS_SOURCE_H:     m_src[63:32]   = merge_bytes(m_src[63:32], data, strb);
         `SNAP_OFS_TARGET_L:     m_tgt[31:0]    = merge_bytes(m_tgt[31:0], data, strb);
         `SNAP_OFS_TARGET_H:     m_tgt[63:32]   = merge_bytes(m_tgt[63:32], data, strb);
         `SNAP_OFS_MB_W:         m_mb_w         = merge_bytes(m_mb_w, data, strb);
         `SNAP_OFS_MB_H:         m_mb_h         = merge_bytes(m_mb_h, data, strb);
         `SNAP_OFS_SOFT_RESET:   m_soft         = merge_bytes(m_soft, data, strb);
         default: ;
      endcase
      // Finish bit latches idle
      if (m_user_control[1])
         m_idle = 1'b1;
      if (m_soft[0])
         model_clear();
   endtask

   function automatic logic [31:0] model_read(input logic [31:0] addr);
      case (addr)
         `SNAP_OFS_SNAP_CONTROL:
            return {m_snap_control[31:4], 1'b1, m_idle, 1'b0, m_snap_control[0]};
         `SNAP_OFS_ACTION_TYPE:    return action_type;
         `SNAP_OFS_ACTION_VERSION: return action_version;
         `SNAP_OFS_CONTEXT:        return m_context;
         `SNAP_OFS_USER_STATUS:    return {29'b0, m_rd_err, m_wr_err, m_done};
         `SNAP_OFS_USER_CONTROL:   return m_user_control;
         `SNAP_OFS_SOURCE_L:       return m_src[31:0];
         `SNAP_OFS_SOURCE_H:       return m_src[63:32];
         `SNAP_OFS_TARGET_L:       return m_tgt[31:0];
         `SNAP_OFS_TARGET_H:       return m_tgt[63:32];
         `SNAP_OFS_MB_W:           return m_mb_w;
         `SNAP_OFS_MB_H:           return m_mb_h;
         `SNAP_OFS_SOFT_RESET:     return m_soft;
         default:                  return `SNAP_RD_DEFAULT;
      endcase
   endfunction

   function automatic logic is_mapped(input logic [31:0] addr);
      return model_read(addr) !== `SNAP_RD_DEFAULT || addr == `SNAP_OFS_SNAP_CONTROL ||
             addr == `SNAP_OFS_USER_STATUS || addr == `SNAP_OFS_ACTION_TYPE ||
             addr == `SNAP_OFS_ACTION_VERSION || (addr >= 32'h34 && addr <= 32'h58 &&
             addr != 32'h48 && addr != 32'h4C) || addr == `SNAP_OFS_CONTEXT;
   endfunction

   //-------------------------------------------------------------------
   // Bus tasks entered and left 1 ns after a rising edge
   //-------------------------------------------------------------------
   task automatic bus_write(input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] strb, input int hold);
      logic hs;
      awaddr  = addr;
      awvalid = 1'b1;
      hs      = 1'b0;
      while (!hs) begin
         hs = awready;
         tick();
      end
      awvalid = 1'b0;
      wdata   = data;
      wstrb   = strb;
      wvalid  = 1'b1;
      hs      = 1'b0;
      while (!hs) begin
         hs = wready;
         tick();
      end
      wvalid = 1'b0;
      // Response due right after the data beat
      compare("bvalid", 64'h1, 64'(bvalid));
      while (!bvalid)
         tick();
      compare("bresp", 64'h0, 64'(bresp));
      if (hold > 0) begin
         bready = 1'b0;
         for (int i = 0; i < hold; i++) begin
            tick();
            compare("bvalid", 64'h1, 64'(bvalid));
         end
         bready = 1'b1;
      end
      tick();
      model_write(addr, data, strb);
   endtask

   task automatic bus_read(input logic [31:0] addr, input int hold, output logic [31:0] data);
      logic hs;
      araddr  = addr;
      arvalid = 1'b1;
      hs      = 1'b0;
      while (!hs) begin
         hs = arready;
         tick();
      end
      arvalid = 1'b0;
      compare("rvalid", 64'h1, 64'(rvalid));
      while (!rvalid)
         tick();
      compare("rresp", 64'h0, 64'(rresp));
      data = rdata;
      if (hold > 0) begin
         rready = 1'b0;
         for (int i = 0; i < hold; i++) begin
            tick();
            compare("rvalid", 64'h1, 64'(rvalid));
            compare("rdata", 64'(data), 64'(rdata));
            // No new read address while the response waits
            compare("arready", 64'h0, 64'(arready));
         end
         rready = 1'b1;
      end
      tick();
   endtask

   task automatic read_check(input logic [31:0] addr, input int hold);
      logic [31:0] got;
      bus_read(addr, hold, got);
      compare($sformatf("rdata@%h", addr), 64'(model_read(addr)), 64'(got));
   endtask

   task automatic check_outputs();
      compare("source_address", m_src, source_address);
      compare("target_address", m_tgt, target_address);
      compare("mb_w", 64'(m_mb_w), 64'(mb_w));
      compare("mb_h", 64'(m_mb_h), 64'(mb_h));
      compare("snap_context", 64'(m_context), 64'(snap_context));
   endtask

   //-------------------------------------------------------------------
   // Stimulus
   //-------------------------------------------------------------------
   initial begin
      logic [31:0] rnd;
      logic [31:0] addr;
      int          idx;
      int          hold;
      int          base;
      rst_n          = 1'b0;
      awvalid        = 1'b0;
      awaddr         = '0;
      wvalid         = 1'b0;
      wdata          = '0;
      wstrb          = '0;
      bready         = 1'b1;
      arvalid        = 1'b0;
      araddr         = '0;
      rready         = 1'b1;
      done_pulse     = 1'b0;
      rd_error       = 1'b0;
      wr_error       = 1'b0;
      action_type    = 32'h0000_0010;
      action_version = 32'h0000_0001;
      model_clear();
      repeat (10) @(posedge clk);
      #1 rst_n = 1'b1;
      tick();

      // Handshake levels out of reset
      compare("awready", 64'h1, 64'(awready));
      compare("arready", 64'h1, 64'(arready));
      compare("wready", 64'h0, 64'(wready));
      compare("bvalid", 64'h0, 64'(bvalid));
      compare("rvalid", 64'h0, 64'(rvalid));
      compare("start_pulse", 64'h0, 64'(start_pulse));

      // Random strobed writes with readback
      for (int i = 0; i < N_RAND; i++) begin
         rnd = next_rand();
         idx = int'(rnd[31:16] % 16'd9);
         addr = rw_ofs[idx];
         bus_write(addr, next_rand(), rnd[11:8], 0);
         read_check(addr, 0);
      end

      // Address halves and configuration outputs
      for (int i = 0; i < 7; i++) begin
         bus_write(cfg_ofs[i], next_rand(), 4'hF, 0);
         check_outputs();
      end

      // Action identity and an unmapped address
      action_type    = next_rand();
      action_version = next_rand();
      read_check(`SNAP_OFS_ACTION_TYPE, 0);
      read_check(`SNAP_OFS_ACTION_VERSION, 0);
      addr = `SNAP_OFS_SNAP_CONTROL;
      while (is_mapped(addr)) begin
         rnd  = next_rand();
         addr = {24'h0, rnd[23:18], 2'b00};
      end
      read_check(addr, 0);

      // Start pulse on the rising edge of user control bit 0 only
      bus_write(`SNAP_OFS_USER_CONTROL, 32'h0, 4'hF, 0);
      base = start_count;
      bus_write(`SNAP_OFS_USER_CONTROL, 32'h1, 4'hF, 0);
      tick();
      compare("start_pulse cycles", 64'h1, 64'(start_count - base));
      bus_write(`SNAP_OFS_USER_CONTROL, 32'h1, 4'hF, 0);
      tick();
      compare("start_pulse cycles", 64'h1, 64'(start_count - base));
      bus_write(`SNAP_OFS_SNAP_CONTROL, 32'h1, 4'h1, 0);
      read_check(`SNAP_OFS_SNAP_CONTROL, 0);

      // Sticky status and the idle flag
      done_pulse = 1'b1;
      tick();
      done_pulse = 1'b0;
      m_done     = 1'b1;
      read_check(`SNAP_OFS_USER_STATUS, 0);
      rd_error = 1'b1;
      wr_error = 1'b1;
      tick();
      rd_error = 1'b0;
      wr_error = 1'b0;
      m_rd_err = 1'b1;
      m_wr_err = 1'b1;
      repeat (3) tick();
      read_check(`SNAP_OFS_USER_STATUS, 0);
      // Finish bit with the start bit kept high
      bus_write(`SNAP_OFS_USER_CONTROL, 32'h3, 4'hF, 0);
      read_check(`SNAP_OFS_SNAP_CONTROL, 0);

      // Soft reset clears the bank and the action state
      bus_write(`SNAP_OFS_SOFT_RESET, 32'h1, 4'h1, 0);
      check_outputs();
      compare("start_pulse", 64'h0, 64'(start_pulse));
      for (int i = 0; i < 9; i++)
         read_check(rw_ofs[i], 0);
      read_check(`SNAP_OFS_USER_STATUS, 0);
      read_check(`SNAP_OFS_SOFT_RESET, 0);

      // Responses held under back-pressure
      for (int i = 0; i < N_BP; i++) begin
         rnd  = next_rand();
         idx  = int'(rnd[31:16] % 16'd9);
         hold = int'(rnd[9:8]) + 1;
         bus_write(rw_ofs[idx], next_rand(), 4'hF, hold);
         read_check(rw_ofs[idx], hold);
      end

      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("TESTBENCH PASSED");
      else
         $display("TESTBENCH FAILED");
      $finish;
   end

endmodule

//--- src/snap_regs_top.sv
//--------------------------------------------------------------------
// AXI-Lite register slave for a SNAP action
//--------------------------------------------------------------------
`timescale 1ns/1ps
`include "snap_regs_defs.svh"

module snap_regs_top (
   input  logic                    clk,
   input  logic                    rst_n,
   // Write address channel
   input  logic                    awvalid,
   input  logic [`SNAP_ADDR_W-1:0] awaddr,
   output logic                    awready,
   // Write data channel
   input  logic                    wvalid,
   input  logic [`SNAP_DATA_W-1:0] wdata,
   input  logic [`SNAP_STRB_W-1:0] wstrb,
   output logic                    wready,
   // Write response channel
   output logic [1:0]              bresp,
   output logic                    bvalid,
   input  logic                    bready,
   // Read address channel
   input  logic                    arvalid,
   input  logic [`SNAP_ADDR_W-1:0] araddr,
   output logic                    arready,
   // Read data channel
   output logic [`SNAP_DATA_W-1:0] rdata,
   output logic [1:0]              rresp,
   output logic                    rvalid,
   input  logic                    rready,
   // Action status in
   input  logic                    done_pulse,
   input  logic                    rd_error,
   input  logic                    wr_error,
   input  logic [`SNAP_DATA_W-1:0] action_type,
   input  logic [`SNAP_DATA_W-1:0] action_version,
   // Action control out
   output logic                    start_pulse,
   output logic [`SNAP_LONG_W-1:0] source_address,
   output logic [`SNAP_LONG_W-1:0] target_address,
   output logic [`SNAP_DATA_W-1:0] mb_w,
   output logic [`SNAP_DATA_W-1:0] mb_h,
   output logic [`SNAP_DATA_W-1:0] snap_context
);

   snap_regs_pkg::reg_wr_t      wr;
   snap_regs_pkg::user_cfg_t    cfg;
   snap_regs_pkg::ctrl_regs_t   ctrl;
   snap_regs_pkg::action_stat_t stat;
   logic                        rd_en;
   logic                        soft_clear;

   axil_ctrl i_axil_ctrl (
      .clk     (clk),
      .rst_n   (rst_n),
      .awvalid (awvalid),
      .awaddr  (awaddr),
      .wvalid  (wvalid),
      .wdata   (wdata),
      .wstrb   (wstrb),
      .bready  (bready),
      .arvalid (arvalid),
      .rready  (rready),
      .awready (awready),
      .wready  (wready),
      .bvalid  (bvalid),
      .arready (arready),
      .rvalid  (rvalid),
      .wr      (wr),
      .rd_en   (rd_en)
   );

   reg_bank i_reg_bank (
      .clk        (clk),
      .rst_n      (rst_n),
      .wr         (wr),
      .cfg        (cfg),
      .ctrl       (ctrl),
      .soft_clear (soft_clear)
   );

   action_ctrl i_action_ctrl (
      .clk         (clk),
      .rst_n       (rst_n),
      .soft_clear  (soft_clear),
      .ctrl        (ctrl),
      .done_pulse  (done_pulse),
      .rd_error    (rd_error),
      .wr_error    (wr_error),
      .start_pulse (start_pulse),
      .stat        (stat)
   );

   read_mux i_read_mux (
      .clk            (clk),
      .rst_n          (rst_n),
      .rd_en          (rd_en),
      .araddr         (araddr),
      .cfg            (cfg),
      .ctrl           (ctrl),
      .stat           (stat),
      .action_type    (action_type),
      .action_version (action_version),
      .rdata          (rdata)
   );

   // Every access completes with OKAY
   assign bresp = `SNAP_RESP_OKAY;
   assign rresp = `SNAP_RESP_OKAY;

   // Configuration out to the action
   assign source_address = cfg.source_address;
   assign target_address = cfg.target_address;
   assign mb_w           = cfg.mb_w;
   assign mb_h           = cfg.mb_h;
   assign snap_context   = ctrl.snap_context;

endmodule

//--- src/read_mux.sv
//--------------------------------------------------------------------
// Read data select, registered on the read address handshake
//--------------------------------------------------------------------
`timescale 1ns/1ps
`include "snap_regs_defs.svh"

module read_mux (
   input  logic                        clk,
   input  logic                        rst_n,
   input  logic                        rd_en,
   input  logic [`SNAP_ADDR_W-1:0]     araddr,
   input  snap_regs_pkg::user_cfg_t    cfg,
   input  snap_regs_pkg::ctrl_regs_t   ctrl,
   input  snap_regs_pkg::action_stat_t stat,
   input  logic [`SNAP_DATA_W-1:0]     action_type,
   input  logic [`SNAP_DATA_W-1:0]     action_version,
   output logic [`SNAP_DATA_W-1:0]     rdata
);

   logic [`SNAP_DATA_W-1:0] snap_control_rd;
   logic [`SNAP_DATA_W-1:0] user_status_rd;

   // Stored upper bits, ready always set, idle, delayed start
   assign snap_control_rd = {ctrl.snap_control[`SNAP_DATA_W-1:4], 1'b1, stat.idle,
                             1'b0, stat.snap_start};
   // Sticky status in the low three bits
   assign user_status_rd  = {{(`SNAP_DATA_W-3){1'b0}}, stat.rd_error, stat.wr_error,
                             stat.done};

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rdata <= '0;
      end else if (rd_en) begin
         case (araddr)
            `SNAP_OFS_SNAP_CONTROL:   rdata <= snap_control_rd;
            `SNAP_OFS_ACTION_TYPE:    rdata <= action_type;
            `SNAP_OFS_ACTION_VERSION: rdata <= action_version;
            `SNAP_OFS_CONTEXT:        rdata <= ctrl.snap_context;
            `SNAP_OFS_USER_STATUS:    rdata <= user_status_rd;
            `SNAP_OFS_USER_CONTROL:   rdata <= ctrl.user_control;
            `SNAP_OFS_SOURCE_L:       rdata <= cfg.source_address[`SNAP_DATA_W-1:0];
            `SNAP_OFS_SOURCE_H:       rdata <= cfg.source_address[`SNAP_LONG_W-1:`SNAP_DATA_W];
            `SNAP_OFS_TARGET_L:       rdata <= cfg.target_address[`SNAP_DATA_W-1:0];
            `SNAP_OFS_TARGET_H:       rdata <= cfg.target_address[`SNAP_LONG_W-1:`SNAP_DATA_W];
            `SNAP_OFS_MB_W:           rdata <= cfg.mb_w;
            `SNAP_OFS_MB_H:           rdata <= cfg.mb_h;
            `SNAP_OFS_SOFT_RESET:     rdata <= ctrl.soft_reset;
            // Marker pattern for holes in the map
            default:                  rdata <= `SNAP_RD_DEFAULT;
         endcase
      end
   end

endmodule

//--- src/action_ctrl.sv
//--------------------------------------------------------------------
// Action control
// Start pulse, idle flag and sticky done and error status
//--------------------------------------------------------------------
`timescale 1ns/1ps

module action_ctrl (
   input  logic                        clk,
   input  logic                        rst_n,
   input  logic                        soft_clear,
   input  snap_regs_pkg::ctrl_regs_t   ctrl,
   input  logic                        done_pulse,
   input  logic                        rd_error,
   input  logic                        wr_error,
   output logic                        start_pulse,
   output snap_regs_pkg::action_stat_t stat
);

   logic start_q;
   logic snap_start_q;
   logic idle_q;
   logic done_q;
   logic rd_err_q;
   logic wr_err_q;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         start_q      <= 1'b0;
         snap_start_q <= 1'b0;
         idle_q       <= 1'b0;
         done_q       <= 1'b0;
         rd_err_q     <= 1'b0;
         wr_err_q     <= 1'b0;
      end else if (soft_clear) begin
         start_q      <= 1'b0;
         snap_start_q <= 1'b0;
         idle_q       <= 1'b0;
         done_q       <= 1'b0;
         rd_err_q     <= 1'b0;
         wr_err_q     <= 1'b0;
      end else begin
         // Delayed start bits for edge detect and readback
         start_q      <= ctrl.user_control[0];
         snap_start_q <= ctrl.snap_control[0];
         // Finish bit marks the action idle
         if (ctrl.user_control[1])
            idle_q <= 1'b1;
         // Sticky until soft reset
         if (done_pulse)
            done_q <= 1'b1;
         if (rd_error)
            rd_err_q <= 1'b1;
         if (wr_error)
            wr_err_q <= 1'b1;
      end
   end

   // Rising edge of user control bit 0
   assign start_pulse = ctrl.user_control[0] & ~start_q;

   always_comb begin
      stat.snap_start = snap_start_q;
      stat.idle       = idle_q;
      stat.done       = done_q;
      stat.rd_error   = rd_err_q;
      stat.wr_error   = wr_err_q;
   end

endmodule

//--- src/reg_bank.sv
//--------------------------------------------------------------------
// Writable register bank with byte strobes and soft reset
//--------------------------------------------------------------------
`timescale 1ns/1ps
`include "snap_regs_defs.svh"

module reg_bank (
   input  logic                       clk,
   input  logic                       rst_n,
   input  snap_regs_pkg::reg_wr_t     wr,
   output snap_regs_pkg::user_cfg_t   cfg,
   output snap_regs_pkg::ctrl_regs_t  ctrl,
   output logic                       soft_clear
);

   // Replace only the strobed bytes of a word
   function automatic logic [`SNAP_DATA_W-1:0] merge(
      input logic [`SNAP_DATA_W-1:0] old_word,
      input logic [`SNAP_DATA_W-1:0] new_word,
      input logic [`SNAP_DATA_W-1:0] byte_mask
   );
      return (new_word & byte_mask) | (old_word & ~byte_mask);
   endfunction

   logic [`SNAP_DATA_W-1:0] mask;
   logic [`SNAP_DATA_W-1:0] snap_control_q;
   logic [`SNAP_DATA_W-1:0] snap_context_q;
   logic [`SNAP_DATA_W-1:0] user_control_q;
   logic [`SNAP_DATA_W-1:0] mb_w_q;
   logic [`SNAP_DATA_W-1:0] mb_h_q;
   logic [`SNAP_DATA_W-1:0] soft_reset_q;
   logic [`SNAP_LONG_W-1:0] source_q;
   logic [`SNAP_LONG_W-1:0] target_q;

   // Strobe bit to byte mask
   always_comb begin
      for (int i = 0; i < `SNAP_STRB_W; i++)
         mask[8*i +: 8] = {8{wr.strb[i]}};
   end

   //------------------------------------------------------------------
   // Storage
   //------------------------------------------------------------------
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         snap_control_q <= '0;
         snap_context_q <= '0;
         user_control_q <= '0;
         mb_w_q         <= '0;
         mb_h_q         <= '0;
         soft_reset_q   <= '0;
         source_q       <= '0;
         target_q       <= '0;
      end else if (soft_clear) begin
         // Whole bank, soft reset word included
         snap_control_q <= '0;
         snap_context_q <= '0;
         user_control_q <= '0;
         mb_w_q         <= '0;
         mb_h_q         <= '0;
         soft_reset_q   <= '0;
         source_q       <= '0;
         target_q       <= '0;
      end else if (wr.en) begin
         case (wr.addr)
            `SNAP_OFS_SNAP_CONTROL: snap_control_q <= merge(snap_control_q, wr.data, mask);
            `SNAP_OFS_CONTEXT:      snap_context_q <= merge(snap_context_q, wr.data, mask);
            `SNAP_OFS_USER_CONTROL: user_control_q <= merge(user_control_q, wr.data, mask);
            // 64-bit addresses, halves written independently
            `SNAP_OFS_SOURCE_L:
               source_q[`SNAP_DATA_W-1:0] <= merge(source_q[`SNAP_DATA_W-1:0], wr.data, mask);
            `SNAP_OFS_SOURCE_H:
               source_q[`SNAP_LONG_W-1:`SNAP_DATA_W] <=
                  merge(source_q[`SNAP_LONG_W-1:`SNAP_DATA_W], wr.data, mask);
            `SNAP_OFS_TARGET_L:
               target_q[`SNAP_DATA_W-1:0] <= merge(target_q[`SNAP_DATA_W-1:0], wr.data, mask);
            `SNAP_OFS_TARGET_H:
               target_q[`SNAP_LONG_W-1:`SNAP_DATA_W] <=
                  merge(target_q[`SNAP_LONG_W-1:`SNAP_DATA_W], wr.data, mask);
            `SNAP_OFS_MB_W:         mb_w_q       <= merge(mb_w_q, wr.data, mask);
            `SNAP_OFS_MB_H:         mb_h_q       <= merge(mb_h_q, wr.data, mask);
            `SNAP_OFS_SOFT_RESET:   soft_reset_q <= merge(soft_reset_q, wr.data, mask);
            // Read-only and unmapped offsets ignored
            default: ;
         endcase
      end
   end

   // Soft reset level, self-clearing on the next edge
   assign soft_clear = soft_reset_q[0];

   always_comb begin
      cfg.source_address = source_q;
      cfg.target_address = target_q;
      cfg.mb_w           = mb_w_q;
      cfg.mb_h           = mb_h_q;
      ctrl.snap_control  = snap_control_q;
      ctrl.snap_context  = snap_context_q;
      ctrl.user_control  = user_control_q;
      ctrl.soft_reset    = soft_reset_q;
   end

endmodule

//--- src/axil_ctrl.sv
//--------------------------------------------------------------------
// AXI-Lite handshake control
// Ready/valid flags, write address capture, write and read strobes
//--------------------------------------------------------------------
`timescale 1ns/1ps
`include "snap_regs_defs.svh"

module axil_ctrl (
   input  logic                    clk,
   input  logic                    rst_n,
   // Write address and data channels
   input  logic                    awvalid,
   input  logic [`SNAP_ADDR_W-1:0] awaddr,
   input  logic                    wvalid,
   input  logic [`SNAP_DATA_W-1:0] wdata,
   input  logic [`SNAP_STRB_W-1:0] wstrb,
   input  logic                    bready,
   // Read channels
   input  logic                    arvalid,
   input  logic                    rready,
   output logic                    awready,
   output logic                    wready,
   output logic                    bvalid,
   output logic                    arready,
   output logic                    rvalid,
   // Register side
   output snap_regs_pkg::reg_wr_t  wr,
   output logic                    rd_en
);

   logic                    aw_hs;
   logic                    w_hs;
   logic                    ar_hs;
   logic                    r_hs;
   logic [`SNAP_ADDR_W-1:0] wr_addr;

   assign aw_hs = awvalid & awready;
   assign w_hs  = wvalid & wready;
   assign ar_hs = arvalid & arready;
   assign r_hs  = rvalid & rready;

   //------------------------------------------------------------------
   // Write path
   //------------------------------------------------------------------
   // Address held until the data beat arrives
   always_ff @(posedge clk) begin
      if (aw_hs)
         wr_addr <= awaddr;
   end

   // Drops once an address is offered, back up after the data beat
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         awready <= 1'b1;
      else if (awvalid)
         awready <= 1'b0;
      else if (w_hs)
         awready <= 1'b1;
   end

   // Open for data the cycle after the address handshake
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         wready <= 1'b0;
      else if (aw_hs)
         wready <= 1'b1;
      else if (wvalid)
         wready <= 1'b0;
   end

   // Response held until the master takes it
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         bvalid <= 1'b0;
      else if (w_hs)
         bvalid <= 1'b1;
      else if (bready)
         bvalid <= 1'b0;
   end

   //------------------------------------------------------------------
   // Read path
   //------------------------------------------------------------------
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         arready <= 1'b1;
      else if (arvalid)
         arready <= 1'b0;
      else if (r_hs)
         arready <= 1'b1;
   end

   // Data valid the cycle after the address is taken
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         rvalid <= 1'b0;
      else if (ar_hs)
         rvalid <= 1'b1;
      else if (rready)
         rvalid <= 1'b0;
   end

   // Write command lives for the data handshake cycle only
   always_comb begin
      wr.en   = w_hs;
      wr.addr = wr_addr;
      wr.data = wdata;
      wr.strb = wstrb;
   end

   assign rd_en = ar_hs;

endmodule

//--- src/snap_regs_pkg.sv
//--------------------------------------------------------------------
// Register slave types shared between the bus, bank and status blocks
//--------------------------------------------------------------------
`include "snap_regs_defs.svh"

package snap_regs_pkg;

   // One register write, valid for the cycle of the data handshake
   typedef struct packed {
      logic                    en;
      logic [`SNAP_ADDR_W-1:0] addr;
      logic [`SNAP_DATA_W-1:0] data;
      logic [`SNAP_STRB_W-1:0] strb;
   } reg_wr_t;

   // Configuration seen by the accelerator datapath
   typedef struct packed {
      logic [`SNAP_LONG_W-1:0] source_address;
      logic [`SNAP_LONG_W-1:0] target_address;
      logic [`SNAP_DATA_W-1:0] mb_w;
      logic [`SNAP_DATA_W-1:0] mb_h;
   } user_cfg_t;

   // Stored control words
   typedef struct packed {
      logic [`SNAP_DATA_W-1:0] snap_control;
      logic [`SNAP_DATA_W-1:0] snap_context;
      logic [`SNAP_DATA_W-1:0] user_control;
      logic [`SNAP_DATA_W-1:0] soft_reset;
   } ctrl_regs_t;

   // Action state flags
   typedef struct packed {
      logic snap_start;
      logic idle;
      logic done;
      logic rd_error;
      logic wr_error;
   } action_stat_t;

endpackage

//--- src/snap_regs_defs.svh
//--------------------------------------------------------------------
// Register slave constants
// Bus widths, register offsets and fixed read values
//--------------------------------------------------------------------
`ifndef SNAP_REGS_DEFS_SVH
`define SNAP_REGS_DEFS_SVH

// Bus widths
`define SNAP_DATA_W 32
`define SNAP_ADDR_W 32
`define SNAP_STRB_W 4
// 64-bit address registers, written as two 32-bit halves
`define SNAP_LONG_W 64

// Register map, byte offsets
`define SNAP_OFS_SNAP_CONTROL   32'h00
`define SNAP_OFS_ACTION_TYPE    32'h10
`define SNAP_OFS_ACTION_VERSION 32'h14
`define SNAP_OFS_CONTEXT        32'h20
`define SNAP_OFS_USER_STATUS    32'h30
`define SNAP_OFS_USER_CONTROL   32'h34
`define SNAP_OFS_SOURCE_L       32'h38
`define SNAP_OFS_SOURCE_H       32'h3C
`define SNAP_OFS_TARGET_L       32'h40
`define SNAP_OFS_TARGET_H       32'h44
`define SNAP_OFS_MB_W           32'h50
`define SNAP_OFS_MB_H           32'h54
`define SNAP_OFS_SOFT_RESET     32'h58

// Fixed values
`define SNAP_RD_DEFAULT 32'h5A5AA5A5
`define SNAP_RESP_OKAY  2'b00

`endif
